// File: include/pitch_settings.svh
`ifndef PITCH_SETTINGS_SVH
`define PITCH_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// sample memory layout
////////////////////////////////////////////////////////////////////////////

`define PITCH_MEM_DEPTH    512
`define PITCH_ADDR_W       9

// index 0 of each region, history sits below it
`define PITCH_SIG_BASE     144
`define PITCH_SCAL_BASE    400

////////////////////////////////////////////////////////////////////////////
// search limits and constants
////////////////////////////////////////////////////////////////////////////

`define PITCH_LAG_MAX      143
`define PITCH_FRAME_MAX    112

`define PITCH_THRESH       27853    // 0.85 in Q15
`define PITCH_ENERGY_LOW   1048576  // below this the signal is scaled up

`endif

// File: source/pitch_pkg.sv
`include "pitch_settings.svh"

package pitch_pkg;

	typedef logic signed [15:0] word_t;  // sample, lag or index
	typedef logic signed [31:0] acc_t;
	typedef logic [`PITCH_ADDR_W-1:0] addr_t;

	typedef struct packed
	{
		word_t pit_min;
		word_t pit_max;
		word_t l_frame;
	} pitch_cfg_t;

	typedef struct packed
	{
		addr_t addr;
		word_t wdata;
		logic  we;
	} mem_req_t;

	// inputs of the shared operator block
	typedef struct packed
	{
		word_t mult_a;
		word_t mult_b;
		word_t mac_a;
		word_t mac_b;
		acc_t  mac_c;
		word_t shift_val;
	} ops_req_t;

	typedef struct packed
	{
		word_t mult_out;
		acc_t  mac_out;
		logic  mac_ovf;
		word_t shr3_out;
		word_t shl3_out;
	} ops_rsp_t;

	typedef enum logic [3:0]
	{
		ol_idle,
		ol_eng_rd,
		ol_eng_acc,
		ol_scl_rd,
		ol_scl_wr,
		ol_srch_go,
		ol_srch_wait,
		ol_dec1,
		ol_dec2
	} ol_state_t;

	typedef enum logic [2:0]
	{
		lag_idle,
		lag_rd_a,
		lag_rd_b,
		lag_mac,
		lag_cmp
	} lag_state_t;

endpackage

// File: source/pitch_config_regs.sv
`timescale 1ns/100ps
`include "pitch_settings.svh"

module pitch_config_regs
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_we,
	input  logic [1:0]            cfg_sel,   // 0 pit_min, 1 pit_max, 2 l_frame
	input  pitch_pkg::word_t      cfg_wdata,
	output pitch_pkg::word_t      cfg_rdata,
	output pitch_pkg::pitch_cfg_t cfg,
	output logic                  cfg_ok
);
	import pitch_pkg::*;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cfg.pit_min <= word_t'(20);
			cfg.pit_max <= word_t'(143);
			cfg.l_frame <= word_t'(80);
		end
		else if (cfg_we)
		begin
			case (cfg_sel)
				2'd0: cfg.pit_min <= cfg_wdata;
				2'd1: cfg.pit_max <= cfg_wdata;
				2'd2: cfg.l_frame <= cfg_wdata;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (cfg_sel)
			2'd0: cfg_rdata = cfg.pit_min;
			2'd1: cfg_rdata = cfg.pit_max;
			2'd2: cfg_rdata = cfg.l_frame;
			default: cfg_rdata = '0;
		endcase
	end

	// all three sections must be non-empty and fit the memory regions
	assign cfg_ok = (cfg.pit_min >= 16'sd1)
		&& (int'(cfg.pit_min) * 4 <= int'(cfg.pit_max))
		&& (cfg.pit_max <= `PITCH_LAG_MAX)
		&& (cfg.l_frame >= 16'sd1)
		&& (cfg.l_frame <= `PITCH_FRAME_MAX);

endmodule

// File: source/sample_ram.sv
`timescale 1ns/100ps
`include "pitch_settings.svh"

module sample_ram
(
	input  logic                clk,
	input  pitch_pkg::mem_req_t req,
	output pitch_pkg::word_t    rdata
);
	import pitch_pkg::*;

	word_t mem [`PITCH_MEM_DEPTH];

	// read-first, rdata shows the old word on a write
	always_ff @(posedge clk)
	begin
		if (req.we)
			mem[req.addr] <= req.wdata;
		rdata <= mem[req.addr];
	end

	addr_in_range: assert property (@(posedge clk)
		req.we |-> int'(req.addr) < `PITCH_MEM_DEPTH);

endmodule

// File: source/dsp_ops.sv
`timescale 1ns/100ps

module dsp_ops
(
	input  pitch_pkg::ops_req_t req,
	output pitch_pkg::ops_rsp_t rsp
);
	import pitch_pkg::*;

	acc_t               mult_prod;
	acc_t               mult_q15;
	acc_t               mac_prod;
	logic signed [33:0] mac_sum;
	logic signed [18:0] shl_wide;

	assign mult_prod = req.mult_a * req.mult_b;
	assign mult_q15 = mult_prod >>> 15;
	assign mac_prod = req.mac_a * req.mac_b;
	assign mac_sum = 34'(req.mac_c) + (34'(mac_prod) <<< 1);  // L_mac doubling
	assign shl_wide = 19'(req.shift_val) <<< 3;

	always_comb
	begin
		// only -1 * -1 can leave the Q15 range
		if (mult_q15 > 32'sd32767)
			rsp.mult_out = 16'sh7fff;
		else
			rsp.mult_out = word_t'(mult_q15);

		if (mac_sum > 34'sd2147483647)
		begin
			rsp.mac_out = 32'sh7fff_ffff;
			rsp.mac_ovf = 1'b1;
		end
		else if (mac_sum < -34'sd2147483648)
		begin
			rsp.mac_out = 32'sh8000_0000;
			rsp.mac_ovf = 1'b1;
		end
		else
		begin
			rsp.mac_out = acc_t'(mac_sum);
			rsp.mac_ovf = 1'b0;
		end

		rsp.shr3_out = req.shift_val >>> 3;

		if (shl_wide > 19'sd32767)
			rsp.shl3_out = 16'sh7fff;
		else if (shl_wide < -19'sd32768)
			rsp.shl3_out = 16'sh8000;
		else
			rsp.shl3_out = word_t'(shl_wide);
	end

endmodule

// File: source/lag_max.sv
`timescale 1ns/100ps
`include "pitch_settings.svh"

module lag_max
(
	input  logic                clk,
	input  logic                reset,
	input  logic                search_start,
	input  pitch_pkg::word_t    lag_hi,
	input  pitch_pkg::word_t    lag_lo,
	input  pitch_pkg::word_t    l_frame,
	input  pitch_pkg::word_t    rdata,
	input  pitch_pkg::ops_rsp_t ops_rsp,
	output pitch_pkg::mem_req_t mem_req,
	output pitch_pkg::ops_req_t ops_req,
	output logic                search_done,
	output pitch_pkg::word_t    best_lag,
	output pitch_pkg::word_t    best_cor
);
	import pitch_pkg::*;

	lag_state_t state;
	word_t      k;         // lag under test
	word_t      j;         // sample index
	word_t      lo_q;
	word_t      opa;       // scal[j] held for the MAC
	acc_t       acc;
	acc_t       best_acc;
	logic       last_j;

	assign last_j = (j == l_frame - 1);
	assign best_cor = best_acc[31:16];

	////////////////////////////////////////////////////////////////////////////
	// address and operator steering
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		mem_req = '0;
		ops_req = '0;
		case (state)
			lag_rd_a: mem_req.addr = addr_t'(`PITCH_SCAL_BASE + j);
			lag_rd_b: mem_req.addr = addr_t'(`PITCH_SCAL_BASE + j - k);
			lag_mac:
			begin
				if (!last_j)
					mem_req.addr = addr_t'(`PITCH_SCAL_BASE + j + 1);  // next scal[j]
				ops_req.mac_a = opa;
				ops_req.mac_b = rdata;  // scal[j-k]
				ops_req.mac_c = acc;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lag_idle;
			search_done <= 1'b0;
			j <= '0;
			k <= '0;
			acc <= '0;
		end
		else
		begin
			search_done <= 1'b0;
			case (state)
				lag_idle:
				begin
					if (search_start)
					begin
						k <= lag_hi;
						j <= '0;
						acc <= '0;
						state <= lag_rd_a;
					end
				end
				lag_rd_a: state <= lag_rd_b;
				lag_rd_b: state <= lag_mac;
				lag_mac:
				begin
					acc <= ops_rsp.mac_out;
					if (last_j)
						state <= lag_cmp;
					else
					begin
						j <= j + 16'sd1;
						state <= lag_rd_b;
					end
				end
				lag_cmp:
				begin
					if (k == lo_q)
					begin
						search_done <= 1'b1;
						state <= lag_idle;
					end
					else
					begin
						k <= k - 16'sd1;
						j <= '0;
						acc <= '0;
						state <= lag_rd_a;
					end
				end
				default: state <= lag_idle;
			endcase
		end
	end

	// running maximum, >= so the lower lag wins a tie
	always_ff @(posedge clk)
	begin
		if (state == lag_idle && search_start)
		begin
			lo_q <= lag_lo;
			best_acc <= 32'sh8000_0000;
			best_lag <= lag_hi;
		end
		if (state == lag_rd_b)
			opa <= rdata;
		if (state == lag_cmp && acc >= best_acc)
		begin
			best_acc <= acc;
			best_lag <= k;
		end
	end

	range_order: assert property (@(posedge clk) disable iff (reset)
		search_start |-> lag_lo <= lag_hi);

endmodule

// File: source/pitch_ol.sv
`timescale 1ns/100ps
`include "pitch_settings.svh"

module pitch_ol
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  pitch_pkg::pitch_cfg_t cfg,
	input  logic                  cfg_ok,
	input  pitch_pkg::word_t      rdata,
	input  pitch_pkg::ops_rsp_t   ops_rsp,
	output pitch_pkg::mem_req_t   mem_req,
	output pitch_pkg::ops_req_t   ops_req,
	output logic                  busy,
	output logic                  done,
	output pitch_pkg::word_t      t_op
);
	import pitch_pkg::*;

	ol_state_t  state;
	pitch_cfg_t cfg_q;       // limits frozen for the whole run
	word_t      i;
	acc_t       energy;
	logic       e_ovf;       // sticky saturation
	logic [1:0] sec;         // section 0 covers the longest lags
	word_t      max1, max2, max3;
	word_t      p1, p2, p3;
	word_t      min_x2, min_x4;
	word_t      lag_hi, lag_lo;
	logic       accept;
	logic       last_i;
	logic       search_start;
	logic       search_done;
	word_t      best_lag;
	word_t      best_cor;
	mem_req_t   lm_mem_req;
	ops_req_t   lm_ops_req;

	assign accept = (state == ol_idle) && start && cfg_ok;
	assign last_i = (i == cfg_q.l_frame - 1);
	assign min_x2 = word_t'(cfg_q.pit_min * 2);
	assign min_x4 = word_t'(cfg_q.pit_min * 4);

	always_comb
	begin
		case (sec)
			2'd0:
			begin
				lag_hi = cfg_q.pit_max;
				lag_lo = min_x4;
			end
			2'd1:
			begin
				lag_hi = min_x4 - 16'sd1;
				lag_lo = min_x2;
			end
			default:
			begin
				lag_hi = min_x2 - 16'sd1;
				lag_lo = cfg_q.pit_min;
			end
		endcase
	end

	lag_max u_lag_max
	(
		.clk          (clk),
		.reset        (reset),
		.search_start (search_start),
		.lag_hi       (lag_hi),
		.lag_lo       (lag_lo),
		.l_frame      (cfg_q.l_frame),
		.rdata        (rdata),
		.ops_rsp      (ops_rsp),
		.mem_req      (lm_mem_req),
		.ops_req      (lm_ops_req),
		.search_done  (search_done),
		.best_lag     (best_lag),
		.best_cor     (best_cor)
	);

	////////////////////////////////////////////////////////////////////////////
	// memory and operator steering
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		mem_req = '0;
		ops_req = '0;
		search_start = 1'b0;
		case (state)
			ol_eng_rd: mem_req.addr = addr_t'(`PITCH_SIG_BASE + i);
			ol_eng_acc:
			begin
				ops_req.mac_a = rdata;
				ops_req.mac_b = rdata;
				ops_req.mac_c = energy;
				if (!last_i)
					mem_req.addr = addr_t'(`PITCH_SIG_BASE + i + 1);  // prefetch
			end
			ol_scl_rd: mem_req.addr = addr_t'(`PITCH_SIG_BASE + i);
			ol_scl_wr:
			begin
				ops_req.shift_val = rdata;
				mem_req.addr = addr_t'(`PITCH_SCAL_BASE + i);
				mem_req.we = 1'b1;
				if (e_ovf)
					mem_req.wdata = ops_rsp.shr3_out;
				else if (energy < `PITCH_ENERGY_LOW)
					mem_req.wdata = ops_rsp.shl3_out;
				else
					mem_req.wdata = rdata;
			end
			ol_srch_go, ol_srch_wait:
			begin
				search_start = (state == ol_srch_go);
				mem_req = lm_mem_req;
				ops_req = lm_ops_req;
			end
			ol_dec1, ol_dec2:
			begin
				ops_req.mult_a = max1;
				ops_req.mult_b = word_t'(`PITCH_THRESH);
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ol_idle;
			busy <= 1'b0;
			done <= 1'b0;
			i <= '0;
			sec <= '0;
			energy <= '0;
			e_ovf <= 1'b0;
			t_op <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ol_idle:
				begin
					if (accept)
					begin
						i <= -cfg.pit_max;
						energy <= '0;
						e_ovf <= 1'b0;
						busy <= 1'b1;
						state <= ol_eng_rd;
					end
				end
				ol_eng_rd: state <= ol_eng_acc;
				ol_eng_acc:
				begin
					energy <= ops_rsp.mac_out;
					e_ovf <= e_ovf | ops_rsp.mac_ovf;
					if (last_i)
					begin
						i <= -cfg_q.pit_max;
						state <= ol_scl_rd;
					end
					else
						i <= i + 16'sd1;
				end
				ol_scl_rd: state <= ol_scl_wr;
				ol_scl_wr:
				begin
					if (last_i)
					begin
						sec <= '0;
						state <= ol_srch_go;
					end
					else
					begin
						i <= i + 16'sd1;
						state <= ol_scl_rd;
					end
				end
				ol_srch_go: state <= ol_srch_wait;
				ol_srch_wait:
				begin
					if (search_done)
					begin
						if (sec == 2'd2)
							state <= ol_dec1;
						else
						begin
							sec <= sec + 2'd1;
							state <= ol_srch_go;
						end
					end
				end
				ol_dec1: state <= ol_dec2;
				ol_dec2:
				begin
					t_op <= (max3 > ops_rsp.mult_out) ? p3 : p1;  // max1 already updated
					done <= 1'b1;
					busy <= 1'b0;
					state <= ol_idle;
				end
				default: state <= ol_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			cfg_q <= cfg;
		if (state == ol_srch_wait && search_done)
		begin
			case (sec)
				2'd0:
				begin
					max1 <= best_cor;
					p1 <= best_lag;
				end
				2'd1:
				begin
					max2 <= best_cor;
					p2 <= best_lag;
				end
				default:
				begin
					max3 <= best_cor;
					p3 <= best_lag;
				end
			endcase
		end
		// shorter lag wins if close enough to the longer one
		if (state == ol_dec1 && max2 > ops_rsp.mult_out)
		begin
			max1 <= max2;
			p1 <= p2;
		end
	end

	done_ends_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> !busy && $past(busy));

endmodule

// File: source/pitch_ol_search.sv
`timescale 1ns/100ps

module pitch_ol_search
(
	input  logic             clk,
	input  logic             reset,
	input  logic             cfg_we,
	input  logic [1:0]       cfg_sel,
	input  pitch_pkg::word_t cfg_wdata,
	input  logic             load_we,
	input  pitch_pkg::addr_t load_addr,
	input  pitch_pkg::word_t load_data,
	input  logic             start,
	output pitch_pkg::word_t cfg_rdata,
	output logic             busy,
	output logic             done,
	output pitch_pkg::word_t t_op
);
	import pitch_pkg::*;

	pitch_cfg_t cfg;
	logic       cfg_ok;
	mem_req_t   host_req;
	mem_req_t   ol_mem_req;
	mem_req_t   ram_req;
	word_t      rdata;
	ops_req_t   ops_req;
	ops_rsp_t   ops_rsp;

	// host owns the memory port while idle
	assign host_req = '{addr: load_addr, wdata: load_data, we: load_we};
	assign ram_req = busy ? ol_mem_req : host_req;

	pitch_config_regs u_cfg
	(
		.clk       (clk),
		.reset     (reset),
		.cfg_we    (cfg_we),
		.cfg_sel   (cfg_sel),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.cfg       (cfg),
		.cfg_ok    (cfg_ok)
	);

	sample_ram u_ram
	(
		.clk   (clk),
		.req   (ram_req),
		.rdata (rdata)
	);

	dsp_ops u_ops
	(
		.req (ops_req),
		.rsp (ops_rsp)
	);

	pitch_ol u_pitch_ol
	(
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.cfg     (cfg),
		.cfg_ok  (cfg_ok),
		.rdata   (rdata),
		.ops_rsp (ops_rsp),
		.mem_req (ol_mem_req),
		.ops_req (ops_req),
		.busy    (busy),
		.done    (done),
		.t_op    (t_op)
	);

endmodule

// File: test/tb_pitch_ol_search.sv
`timescale 1ns/100ps
`include "pitch_settings.svh"

module tb_pitch_ol_search;
	import pitch_pkg::*;

	localparam int off = `PITCH_LAG_MAX;                     // sample index 0 in sig[]
	localparam int sig_len = `PITCH_LAG_MAX + `PITCH_FRAME_MAX;
	localparam int run_cycles = 2 * `PITCH_FRAME_MAX * `PITCH_LAG_MAX + 4 * sig_len + 200;
	localparam int run_count = 6;
	localparam int timeout_cycles = run_count * (run_cycles + sig_len + 50) + 1000;

	logic       clk = 1'b0;
	logic       reset;
	logic       cfg_we;
	logic [1:0] cfg_sel;
	word_t      cfg_wdata;
	logic       load_we;
	addr_t      load_addr;
	word_t      load_data;
	logic       start;
	word_t      cfg_rdata;
	logic       busy;
	logic       done;
	word_t      t_op;

	int          sig [sig_len];
	int          scal [sig_len];
	int          model_path;      // 0 copy, 1 shift up, 2 shift down
	logic [15:0] lfsr_state = 16'd44447;
	int          cycle_count = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          tests_failed = 0;

	pitch_ol_search dut
	(
		.clk       (clk),
		.reset     (reset),
		.cfg_we    (cfg_we),
		.cfg_sel   (cfg_sel),
		.cfg_wdata (cfg_wdata),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.start     (start),
		.cfg_rdata (cfg_rdata),
		.busy      (busy),
		.done      (done),
		.t_op      (t_op)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: the search did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// noise and arithmetic helpers
	////////////////////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11
	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int noise(input int nbits);
		int v;
		v = 0;
		for (int n = 0; n < nbits; n++)
			v = (v << 1) | int'(lfsr_bit());
		return v - (1 << (nbits - 1));  // centred on zero
	endfunction

	function automatic int clip16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	function automatic int wrap(input int i, input int p);
		return ((i % p) + p) % p;
	endfunction

	function automatic int l_mac(input int acc, input int a, input int b, output bit ovf);
		longint sum;
		sum = longint'(acc) + 2 * longint'(a) * longint'(b);
		ovf = 1'b0;
		if (sum > 64'sd2147483647)
		begin
			sum = 64'sd2147483647;
			ovf = 1'b1;
		end
		else if (sum < -64'sd2147483648)
		begin
			sum = -64'sd2147483648;
			ovf = 1'b1;
		end
		return int'(sum);
	endfunction

	function automatic int q15_mult(input int a, input int b);
		longint p;
		p = (longint'(a) * longint'(b)) >>> 15;
		if (p > 32767)
			p = 32767;
		return int'(p);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int reference_lag(input int pit_min, input int pit_max, input int l_frame);
		int  energy;
		bit  e_ovf;
		bit  o;
		int  acc;
		int  best_acc;
		int  best_lag;
		int  hi;
		int  lo;
		int  thr;
		int  sec_max [3];
		int  sec_lag [3];
		energy = 0;
		e_ovf = 1'b0;
		for (int i = -pit_max; i < l_frame; i++)
		begin
			energy = l_mac(energy, sig[i + off], sig[i + off], o);
			e_ovf = e_ovf | o;
		end
		model_path = e_ovf ? 2 : (energy < `PITCH_ENERGY_LOW) ? 1 : 0;
		for (int i = -pit_max; i < l_frame; i++)
		begin
			case (model_path)
				2: scal[i + off] = sig[i + off] >>> 3;
				1: scal[i + off] = clip16(sig[i + off] * 8);
				default: scal[i + off] = sig[i + off];
			endcase
		end
		for (int s = 0; s < 3; s++)
		begin
			hi = (s == 0) ? pit_max : (s == 1) ? 4 * pit_min - 1 : 2 * pit_min - 1;
			lo = (s == 0) ? 4 * pit_min : (s == 1) ? 2 * pit_min : pit_min;
			best_acc = 32'sh8000_0000;
			best_lag = hi;
			for (int k = hi; k >= lo; k--)
			begin
				acc = 0;
				for (int j = 0; j < l_frame; j++)
					acc = l_mac(acc, scal[j + off], scal[j - k + off], o);
				if (acc >= best_acc)  // walking down, so ties land on the shorter lag
				begin
					best_acc = acc;
					best_lag = k;
				end
			end
			sec_max[s] = best_acc >>> 16;
			sec_lag[s] = best_lag;
		end
		thr = q15_mult(sec_max[0], `PITCH_THRESH);
		if (sec_max[1] > thr)
		begin
			sec_max[0] = sec_max[1];
			sec_lag[0] = sec_lag[1];
		end
		thr = q15_mult(sec_max[0], `PITCH_THRESH);
		if (sec_max[2] > thr)
			sec_lag[0] = sec_lag[2];
		return sec_lag[0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus tasks and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input string test, input string what, input int expected,
		input int actual);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("CHECK FAILED %s: %s expected %0d actual %0d", test, what, expected, actual);
		end
	endtask

	task automatic report_test(input string test, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("[%s] ok", test);
		else
		begin
			tests_failed++;
			$display("[%s] %0d error(s)", test, errors - errors_before);
		end
	endtask

	task automatic write_cfg(input int sel, input int value);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_sel <= 2'(sel);
		cfg_wdata <= word_t'(value);
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic read_cfg(input string test, input int sel, input int expected);
		@(posedge clk);
		cfg_sel <= 2'(sel);
		@(negedge clk);
		check_eq(test, $sformatf("cfg_rdata sel %0d", sel), expected, cfg_rdata);
	endtask

	task automatic load_signal();
		for (int idx = 0; idx < sig_len; idx++)
		begin
			@(posedge clk);
			load_we <= 1'b1;
			load_addr <= addr_t'(`PITCH_SIG_BASE - off + idx);
			load_data <= word_t'(sig[idx]);
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_search(input string test, input int pit_min, input int pit_max,
		input int l_frame);
		int expected;
		write_cfg(0, pit_min);
		write_cfg(1, pit_max);
		write_cfg(2, l_frame);
		expected = reference_lag(pit_min, pit_max, l_frame);
		pulse_start();
		@(negedge clk);
		check_eq(test, "busy after start", 1, busy);
		while (done !== 1'b1)
			@(negedge clk);
		check_eq(test, "busy at done", 0, busy);
		check_eq(test, "t_op", expected, t_op);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_and_config();
		int e0;
		e0 = errors;
		@(negedge clk);
		check_eq("reset_and_config", "done", 0, done);
		check_eq("reset_and_config", "busy", 0, busy);
		check_eq("reset_and_config", "t_op", 0, t_op);
		read_cfg("reset_and_config", 0, 20);
		read_cfg("reset_and_config", 1, 143);
		read_cfg("reset_and_config", 2, 80);
		write_cfg(0, 31);
		write_cfg(1, 130);
		write_cfg(2, 100);
		read_cfg("reset_and_config", 0, 31);
		read_cfg("reset_and_config", 1, 130);
		read_cfg("reset_and_config", 2, 100);
		report_test("reset_and_config", e0);
	endtask

	task automatic test_copy_path();
		int e0;
		e0 = errors;
		for (int i = -off; i < `PITCH_FRAME_MAX; i++)
			sig[i + off] = clip16(wrap(i, 50) * 80 - 2000 + noise(7));
		load_signal();
		run_search("copy_path", 20, 143, 80);
		check_eq("copy_path", "scaling path of stimulus", 0, model_path);
		report_test("copy_path", e0);
	endtask

	task automatic test_shift_up();
		int e0;
		e0 = errors;
		for (int i = -off; i < `PITCH_FRAME_MAX; i++)
			sig[i + off] = clip16(wrap(i, 40) * 2 - 40 + noise(3));
		load_signal();
		run_search("shift_up", 20, 143, 80);
		check_eq("shift_up", "scaling path of stimulus", 1, model_path);
		report_test("shift_up", e0);
	endtask

	task automatic test_shift_down();
		int e0;
		e0 = errors;
		for (int i = -off; i < `PITCH_FRAME_MAX; i++)
			sig[i + off] = (wrap(i, 40) < 20) ? 32767 : -32768;
		load_signal();
		run_search("shift_down", 20, 143, 80);
		check_eq("shift_down", "scaling path of stimulus", 2, model_path);
		report_test("shift_down", e0);
	endtask

	task automatic test_threshold();
		int e0;
		e0 = errors;
		// short pulse every 30 samples, multiples land in the longer sections
		for (int i = -off; i < `PITCH_FRAME_MAX; i++)
			sig[i + off] = clip16(((wrap(i, 30) < 5) ? 3000 : -500) + noise(5));
		load_signal();
		run_search("threshold", 20, 143, 80);
		// a multiple of the period in section one must lose to a shorter lag
		check_eq("threshold", "lag below section one", 1, int'(t_op < 16'sd80));
		report_test("threshold", e0);
	endtask

	task automatic test_illegal_then_back_to_back();
		int e0;
		int busy_seen;
		e0 = errors;
		busy_seen = 0;
		for (int i = -off; i < `PITCH_FRAME_MAX; i++)
			sig[i + off] = clip16(wrap(i, 37) * 80 - 1500 + noise(6));
		load_signal();
		write_cfg(1, 143);
		write_cfg(0, 40);  // 4 * 40 above pit_max
		pulse_start();
		repeat (20)
		begin
			@(negedge clk);
			if (busy || done)
				busy_seen++;
		end
		check_eq("illegal_start", "cycles busy after illegal start", 0, busy_seen);
		run_search("back_to_back_a", 18, 120, 60);
		run_search("back_to_back_b", 25, 100, 112);
		report_test("illegal_then_back_to_back", e0);
	endtask

	initial
	begin
		reset = 1'b1;
		cfg_we = 1'b0;
		cfg_sel = 2'd0;
		cfg_wdata = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		test_reset_and_config();
		test_copy_path();
		test_shift_up();
		test_shift_down();
		test_threshold();
		test_illegal_then_back_to_back();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: pitch_ol_search.f
+incdir+include
source/pitch_pkg.sv
source/pitch_config_regs.sv
source/sample_ram.sv
source/dsp_ops.sv
source/lag_max.sv
source/pitch_ol.sv
source/pitch_ol_search.sv
test/tb_pitch_ol_search.sv

// File: Bender.yml
package:
  name: pitch_ol_search

export_include_dirs:
  - include

sources:
  - files:
      - source/pitch_pkg.sv
      - source/pitch_config_regs.sv
      - source/sample_ram.sv
      - source/dsp_ops.sv
      - source/lag_max.sv
      - source/pitch_ol.sv
      - source/pitch_ol_search.sv
  - target: test
    files:
      - test/tb_pitch_ol_search.sv
